//--- verilog.f
hdl/mul_pkg.sv
hdl/compressor_4_2.sv
hdl/compressor_row.sv
hdl/reduction_level.sv
hdl/partial_products.sv
hdl/kogge_stone_adder.sv
hdl/wallace_multiplier.sv
test/clock_gen.sv
test/wallace_multiplier_chk.sv
test/wallace_multiplier_tb.sv

//--- test/wallace_multiplier_tb.sv
`timescale 1ns/100ps
`default_nettype none

module wallace_multiplier_tb;

    import mul_pkg::*;

    localparam int CLOCK_PERIOD = 40;
    localparam int RESET_CYCLES = 4;
    localparam int SEED         = 91396;

    // Cycle budget per test including its closing drain
    localparam int HOLD_CYCLES      = 6;
    localparam int CORNER_COUNT     = 6;
    localparam int STREAM_COUNT     = 200;
    localparam int MID_RUN_COUNT    = 20;
    localparam int RESET_TEST_LEN   = HOLD_CYCLES + PIPE_LATENCY;
    localparam int CORNER_TEST_LEN  = CORNER_COUNT + PIPE_LATENCY;
    localparam int WALK_TEST_LEN    = 2 * OPERAND_WIDTH + PIPE_LATENCY;
    localparam int STREAM_TEST_LEN  = STREAM_COUNT + PIPE_LATENCY;
    localparam int MID_TEST_LEN     = 2 * MID_RUN_COUNT + 1 + PIPE_LATENCY;
    localparam int TOTAL_CYCLES     = RESET_CYCLES + RESET_TEST_LEN + CORNER_TEST_LEN
                                    + WALK_TEST_LEN + STREAM_TEST_LEN + MID_TEST_LEN;

    logic                     clock;
    logic                     por_reset;
    logic                     test_reset;
    logic                     dut_reset;
    logic [OPERAND_WIDTH-1:0] a;
    logic [OPERAND_WIDTH-1:0] b;
    logic [PRODUCT_WIDTH-1:0] product;

    // Expected product per driven cycle with the oldest at the front
    logic [PRODUCT_WIDTH-1:0] expected_q [$];

    int pass_count = 0;
    int fail_count = 0;

    assign dut_reset = por_reset | test_reset;

    clock_gen #(
        .period       (CLOCK_PERIOD),
        .reset_cycles (RESET_CYCLES)
    ) u_clock_gen (
        .clock (clock),
        .reset (por_reset)
    );

    wallace_multiplier u_dut (
        .clock   (clock),
        .reset   (dut_reset),
        .a       (a),
        .b       (b),
        .product (product)
    );

    task automatic check_value(input string name, input logic [PRODUCT_WIDTH-1:0] actual,
                               input logic [PRODUCT_WIDTH-1:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, actual, expected);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    // Check the product now due and present new operands on one falling edge
    task automatic drive_cycle(input logic [OPERAND_WIDTH-1:0] op_a,
                               input logic [OPERAND_WIDTH-1:0] op_b,
                               input logic hold_reset);
        logic [PRODUCT_WIDTH-1:0] due;
        @(negedge clock);
        if (expected_q.size() == PIPE_LATENCY) begin
            due = expected_q.pop_front();
            check_value("product", product, due);
        end
        a          = op_a;
        b          = op_b;
        test_reset = hold_reset;
        if (hold_reset) begin
            // Reset wipes everything in flight along with this pair
            foreach (expected_q[i]) begin
                expected_q[i] = '0;
            end
            expected_q.push_back('0);
        end else begin
            expected_q.push_back(PRODUCT_WIDTH'(op_a) * PRODUCT_WIDTH'(op_b));
        end
    endtask

    task automatic drain_pipeline();
        repeat (PIPE_LATENCY) drive_cycle('0, '0, 1'b0);
    endtask

    function automatic logic [OPERAND_WIDTH-1:0] random_operand();
        return OPERAND_WIDTH'($urandom());
    endfunction

    task automatic report_test(input string name, input int errors_before);
        if (fail_count == errors_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d mismatches", name, fail_count - errors_before);
        end
    endtask

    task automatic reset_clears();
        int errors_before;
        errors_before = fail_count;
        repeat (HOLD_CYCLES) begin
            drive_cycle(random_operand() | 16'h0001, random_operand() | 16'h0001, 1'b1);
        end
        drain_pipeline();
        report_test("reset_clears", errors_before);
    endtask

    task automatic corner_operands();
        logic [OPERAND_WIDTH-1:0] corner_a [CORNER_COUNT];
        logic [OPERAND_WIDTH-1:0] corner_b [CORNER_COUNT];
        int errors_before;
        errors_before = fail_count;
        corner_a = '{16'h0000, 16'h0001, 16'hFFFF, 16'h0001, 16'hFFFF, 16'h8000};
        corner_b = '{16'h0000, 16'h0001, 16'h0001, 16'hFFFF, 16'hFFFF, 16'h8000};
        for (int i = 0; i < CORNER_COUNT; i++) begin
            drive_cycle(corner_a[i], corner_b[i], 1'b0);
        end
        drain_pipeline();
        report_test("corner_operands", errors_before);
    endtask

    task automatic walking_one();
        logic [OPERAND_WIDTH-1:0] partner;
        int errors_before;
        errors_before = fail_count;
        for (int i = 0; i < OPERAND_WIDTH; i++) begin
            drive_cycle(OPERAND_WIDTH'(1) << i, 16'hFFFF, 1'b0);
        end
        for (int i = 0; i < OPERAND_WIDTH; i++) begin
            partner = random_operand();
            drive_cycle(OPERAND_WIDTH'(1) << i, partner, 1'b0);
        end
        drain_pipeline();
        report_test("walking_one", errors_before);
    endtask

    task automatic back_to_back_stream();
        int errors_before;
        errors_before = fail_count;
        repeat (STREAM_COUNT) begin
            drive_cycle(random_operand(), random_operand(), 1'b0);
        end
        drain_pipeline();
        report_test("streaming", errors_before);
    endtask

    task automatic reset_mid_stream();
        int errors_before;
        errors_before = fail_count;
        repeat (MID_RUN_COUNT) begin
            drive_cycle(random_operand(), random_operand(), 1'b0);
        end
        drive_cycle(random_operand(), random_operand(), 1'b1);
        repeat (MID_RUN_COUNT) begin
            drive_cycle(random_operand(), random_operand(), 1'b0);
        end
        drain_pipeline();
        report_test("reset_mid_stream", errors_before);
    endtask

    initial begin
        #(2 * TOTAL_CYCLES * CLOCK_PERIOD);
        $display("Watchdog expired: the tests did not finish within %0d cycles",
                 2 * TOTAL_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int assert_failures;
        a          = '0;
        b          = '0;
        test_reset = 1'b0;
        void'($urandom(SEED));
        wait (por_reset == 1'b0);

        reset_clears();
        corner_operands();
        walking_one();
        back_to_back_stream();
        reset_mid_stream();

        assert_failures = u_dut.u_chk.failures;
        if (assert_failures != 0) begin
            $display("Checker assertions failed %0d times", assert_failures);
        end
        $display("Checks: %0d matched, %0d mismatched", pass_count, fail_count);
        if (fail_count == 0 && assert_failures == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/wallace_multiplier_chk.sv
`timescale 1ns/100ps
`default_nettype none

module wallace_multiplier_chk (
    input logic                              clock,
    input logic                              reset,
    input logic [mul_pkg::OPERAND_WIDTH-1:0] a,
    input logic [mul_pkg::OPERAND_WIDTH-1:0] b,
    input logic [mul_pkg::PRODUCT_WIDTH-1:0] product
);

    import mul_pkg::*;

    int failures = 0;

    // Consecutive rising edges with reset low, saturating
    logic [2:0] quiet_edges = '0;
    logic       seen_reset  = 1'b0;

    always_ff @(posedge clock) begin
        if (reset) begin
            quiet_edges <= '0;
            seen_reset  <= 1'b1;
        end else if (quiet_edges < PIPE_LATENCY) begin
            quiet_edges <= quiet_edges + 3'd1;
        end
    end

    reset_clears_product: assert property (@(posedge clock) reset |=> product == '0)
        else begin
            failures++;
            $error("product not zero one edge after reset");
        end

    // Whole pipeline free of reset, so the oldest operands in flight must show up
    product_latency: assert property (@(posedge clock)
        quiet_edges == PIPE_LATENCY |->
            product == PRODUCT_WIDTH'($past(a, PIPE_LATENCY))
                       * PRODUCT_WIDTH'($past(b, PIPE_LATENCY)))
        else begin
            failures++;
            $error("product does not match operands from %0d edges earlier", PIPE_LATENCY);
        end

    product_known: assert property (@(posedge clock) seen_reset |-> !$isunknown(product))
        else begin
            failures++;
            $error("product has unknown bits after reset");
        end

endmodule

bind wallace_multiplier wallace_multiplier_chk u_chk (
    .clock   (clock),
    .reset   (reset),
    .a       (a),
    .b       (b),
    .product (product)
);

`default_nettype wire

//--- test/clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module clock_gen #(
    parameter int period       = 40,
    parameter int reset_cycles = 4
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #(period / 2) clock = ~clock;
    end

    // Released on a falling edge so the DUT never sees it change near a rising edge
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- hdl/wallace_multiplier.sv
`timescale 1ns/100ps
`default_nettype none

module wallace_multiplier (
    input  logic                              clock,
    input  logic                              reset,
    input  logic [mul_pkg::OPERAND_WIDTH-1:0] a,
    input  logic [mul_pkg::OPERAND_WIDTH-1:0] b,
    output logic [mul_pkg::PRODUCT_WIDTH-1:0] product
);

    import mul_pkg::*;

    // 16 rows, then 8, 4 and finally 2
    row_t pp_rows     [PP_ROWS];
    row_t level1_rows [PP_ROWS/2];
    row_t level2_rows [PP_ROWS/4];
    row_t level3_rows [PP_ROWS/8];

    partial_products u_partial_products (
        .clock (clock),
        .reset (reset),
        .a     (a),
        .b     (b),
        .rows  (pp_rows)
    );

    reduction_level #(.in_rows(PP_ROWS)) u_level1 (
        .clock    (clock),
        .reset    (reset),
        .rows_in  (pp_rows),
        .rows_out (level1_rows)
    );

    reduction_level #(.in_rows(PP_ROWS/2)) u_level2 (
        .clock    (clock),
        .reset    (reset),
        .rows_in  (level1_rows),
        .rows_out (level2_rows)
    );

    reduction_level #(.in_rows(PP_ROWS/4)) u_level3 (
        .clock    (clock),
        .reset    (reset),
        .rows_in  (level2_rows),
        .rows_out (level3_rows)
    );

    // Sum and carry rows resolved without a further register
    kogge_stone_adder u_final_adder (
        .addend_a (level3_rows[0]),
        .addend_b (level3_rows[1]),
        .sum      (product)
    );

endmodule

`default_nettype wire

//--- hdl/kogge_stone_adder.sv
`timescale 1ns/100ps
`default_nettype none

module kogge_stone_adder (
    input  mul_pkg::row_t addend_a,
    input  mul_pkg::row_t addend_b,
    output mul_pkg::row_t sum
);

    import mul_pkg::*;

    // Group generate per prefix level, level 0 is bitwise
    logic [PREFIX_STAGES:0][PRODUCT_WIDTH-1:0]   gen;
    // The last level needs no group propagate
    logic [PREFIX_STAGES-1:0][PRODUCT_WIDTH-1:0] prop;
    logic [PRODUCT_WIDTH-1:0]                    carry;

    assign gen[0]  = addend_a & addend_b;
    assign prop[0] = addend_a ^ addend_b;

    genvar level;
    genvar bit_idx;
    generate
        for (level = 1; level <= PREFIX_STAGES; level++) begin : g_level
            localparam int DIST = 1 << (level - 1);

            for (bit_idx = 0; bit_idx < PRODUCT_WIDTH; bit_idx++) begin : g_bit
                if (bit_idx >= DIST) begin : g_merge
                    assign gen[level][bit_idx] = gen[level-1][bit_idx]
                        | (prop[level-1][bit_idx] & gen[level-1][bit_idx-DIST]);

                    if (level < PREFIX_STAGES) begin : g_prop
                        assign prop[level][bit_idx] = prop[level-1][bit_idx]
                            & prop[level-1][bit_idx-DIST];
                    end
                end else begin : g_pass
                    // Span already reaches bit 0
                    assign gen[level][bit_idx] = gen[level-1][bit_idx];

                    if (level < PREFIX_STAGES) begin : g_prop
                        assign prop[level][bit_idx] = prop[level-1][bit_idx];
                    end
                end
            end
        end
    endgenerate

    // No carry into bit 0, the carry out of the top bit is dropped
    assign carry = {gen[PREFIX_STAGES][PRODUCT_WIDTH-2:0], 1'b0};

    assign sum = prop[0] ^ carry;

endmodule

`default_nettype wire

//--- hdl/partial_products.sv
`timescale 1ns/100ps
`default_nettype none

module partial_products (
    input  logic                              clock,
    input  logic                              reset,
    input  logic [mul_pkg::OPERAND_WIDTH-1:0] a,
    input  logic [mul_pkg::OPERAND_WIDTH-1:0] b,
    output mul_pkg::row_t                     rows [mul_pkg::PP_ROWS]
);

    import mul_pkg::*;

    row_t next_rows [PP_ROWS];

    genvar r;
    generate
        for (r = 0; r < PP_ROWS; r++) begin : g_row
            logic [OPERAND_WIDTH-1:0] masked;

            // b gated by one bit of a
            assign masked = b & {OPERAND_WIDTH{a[r]}};

            // Zero extend, then align to weight 2^r
            assign next_rows[r] = row_t'(masked) << r;
        end
    endgenerate

    always_ff @(posedge clock) begin
        if (reset) begin
            rows <= '{default: '0};
        end else begin
            rows <= next_rows;
        end
    end

endmodule

`default_nettype wire

//--- hdl/reduction_level.sv
`timescale 1ns/100ps
`default_nettype none

module reduction_level #(
    parameter int in_rows = 16
) (
    input  logic          clock,
    input  logic          reset,
    input  mul_pkg::row_t rows_in  [in_rows],
    output mul_pkg::row_t rows_out [in_rows/2]
);

    import mul_pkg::*;

    localparam int GROUPS   = in_rows / 4;
    localparam int OUT_ROWS = in_rows / 2;

    row_t next_rows [OUT_ROWS];

    genvar grp;
    genvar k;
    generate
        for (grp = 0; grp < GROUPS; grp++) begin : g_group
            row_t group_in [4];

            // Four consecutive input rows per compressor row
            for (k = 0; k < 4; k++) begin : g_pick
                assign group_in[k] = rows_in[4*grp + k];
            end

            compressor_row u_row (
                .rows_in   (group_in),
                .sum_row   (next_rows[2*grp]),
                .carry_row (next_rows[2*grp + 1])
            );
        end
    endgenerate

    // Pipeline register for this level
    always_ff @(posedge clock) begin
        if (reset) begin
            rows_out <= '{default: '0};
        end else begin
            rows_out <= next_rows;
        end
    end

endmodule

`default_nettype wire

//--- hdl/compressor_row.sv
`timescale 1ns/100ps
`default_nettype none

module compressor_row (
    input  mul_pkg::row_t rows_in [4],
    output mul_pkg::row_t sum_row,
    output mul_pkg::row_t carry_row
);

    import mul_pkg::*;

    // Lateral carry chain, entry i feeds column i
    logic [PRODUCT_WIDTH:0]   lateral;
    logic [PRODUCT_WIDTH-1:0] column_carry;

    assign lateral[0] = 1'b0;

    genvar col;
    generate
        for (col = 0; col < PRODUCT_WIDTH; col++) begin : g_column
            compressor_4_2 u_cell (
                .in0       (rows_in[0][col]),
                .in1       (rows_in[1][col]),
                .in2       (rows_in[2][col]),
                .in3       (rows_in[3][col]),
                .carry_in  (lateral[col]),
                .sum       (sum_row[col]),
                .carry     (column_carry[col]),
                .carry_out (lateral[col+1])
            );
        end
    endgenerate

    // Column carries weigh one place up
    // Anything leaving bit 31 falls off, the product is taken modulo 2^32
    assign carry_row = {column_carry[PRODUCT_WIDTH-2:0], 1'b0};

endmodule

`default_nettype wire

//--- hdl/compressor_4_2.sv
`timescale 1ns/100ps
`default_nettype none

module compressor_4_2 (
    input  logic in0,
    input  logic in1,
    input  logic in2,
    input  logic in3,
    input  logic carry_in,
    output logic sum,
    output logic carry,
    output logic carry_out
);

    logic mid_sum;

    // First full adder, its carry goes sideways to the next column
    assign mid_sum   = in0 ^ in1 ^ in2;
    assign carry_out = (in0 & in1) | (in1 & in2) | (in2 & in0);

    // Second full adder folds in the fourth bit and the incoming lateral carry
    assign sum   = mid_sum ^ in3 ^ carry_in;
    assign carry = (mid_sum & in3) | (in3 & carry_in) | (carry_in & mid_sum);

endmodule

`default_nettype wire

//--- hdl/mul_pkg.sv
`default_nettype none

package mul_pkg;

    // Operand and product widths
    localparam int OPERAND_WIDTH = 16;
    localparam int PRODUCT_WIDTH = 2 * OPERAND_WIDTH;

    // One partial product row per bit of the multiplier operand
    localparam int PP_ROWS = OPERAND_WIDTH;

    // Prefix levels needed to span the full product width
    localparam int PREFIX_STAGES = $clog2(PRODUCT_WIDTH);

    // Partial product register plus three reduction levels
    localparam int PIPE_LATENCY = 4;

    // One row of the dot matrix, already aligned to its column weight
    typedef logic [PRODUCT_WIDTH-1:0] row_t;

endpackage

`default_nettype wire
